// ==== mcu_pkg.sv ====
/*
  Vector store control encodings. SEW and width codes above 2 (64 bit) are not
  supported, and LMUL code 4 is reserved. WR_PIPE_DEPTH must be at least 2.
*/
`default_nettype none

package mcu_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // SEW, LMUL, EMUL and element width codes
  localparam int VTYPE_W = 3;
  // Address and stride
  localparam int ADDR_W = 32;
  // Buffer read latency that the write-valid pipeline tracks
  localparam int WR_PIPE_DEPTH = 2;

  //////////////////////////////
  // Types
  //////////////////////////////

  // LMUL code: 0..3 -> 1, 2, 4, 8 and 5..7 -> 1/8, 1/4, 1/2
  // Width/SEW code: 0..2 -> 8, 16, 32 bit
  typedef logic [VTYPE_W-1:0] vcode_t;

  typedef logic [ADDR_W-1:0] addr_t;

  typedef enum logic [1:0] {
    kind_unit,
    kind_strided,
    kind_indexed
  } store_kind_e;

  typedef enum logic [3:0] {
    s_idle,
    s_unit_prep,
    s_unit_tx,
    s_strided_prep,
    s_strided_tx_prep,
    s_strided_tx,
    s_indexed_prep,
    s_indexed_tx_prep,
    s_indexed_tx
  } store_state_e;

  //////////////////////////////
  // EMUL = (EEW / SEW) * LMUL
  //////////////////////////////

  // The LMUL code is log2(LMUL) in 3-bit two's complement and the
  // width codes are log2(bits / 8), so EMUL is a sum of logs mod 8.
  // Invalid combinations wrap and give a meaningless code.
  function automatic vcode_t calc_emul(input vcode_t eew,
                                       input vcode_t sew,
                                       input vcode_t lmul);
    vcode_t emul;
    emul = lmul + eew - sew;
    return emul;
  endfunction

endpackage

`default_nettype wire

// ==== mcu_store_cfg_if.sv ====
/*
  Store configuration between the config block and the FSM. The config values
  already show the new request in the cycle where accept is high.
*/
`timescale 1ns/1ps
`default_nettype none

interface mcu_store_cfg_if import mcu_pkg::*; ();

  store_kind_e kind;
  vcode_t      data_sew;
  vcode_t      data_lmul;
  vcode_t      idx_sew;
  vcode_t      idx_lmul;
  addr_t       base_addr;
  addr_t       stride;
  // One-cycle capture strobe from the FSM
  logic        accept;

  modport cfg_src (
    input  accept,
    output kind, data_sew, data_lmul, idx_sew, idx_lmul, base_addr, stride
  );

  modport cfg_snk (
    output accept,
    input  kind, data_sew, data_lmul, idx_sew, idx_lmul, base_addr, stride
  );

endinterface

`default_nettype wire

// ==== mcu_store_cfg.sv ====
/*
  Store request capture. Type bits are one-hot with unit over strided over
  indexed; no type bit set is taken as unit. Invalid EMUL is not flagged.
*/
`timescale 1ns/1ps
`default_nettype none

module mcu_store_cfg import mcu_pkg::*; (
  input  wire logic   clk,
  input  wire logic   rstn,
  input  wire vcode_t sew_i,
  input  wire vcode_t lmul_i,
  input  wire vcode_t width_i,
  input  wire addr_t  base_addr_i,
  input  wire addr_t  stride_i,
  input  wire logic   unit_i,
  input  wire logic   strided_i,
  input  wire logic   indexed_i,
  mcu_store_cfg_if.cfg_src cfg
);

  store_kind_e kind_d, kind_q;
  vcode_t      emul;
  vcode_t      data_sew_d, data_sew_q;
  vcode_t      data_lmul_d, data_lmul_q;
  vcode_t      idx_sew_d, idx_sew_q;
  vcode_t      idx_lmul_d, idx_lmul_q;
  addr_t       base_addr_q;
  addr_t       stride_q;

  //////////////////////////////
  // Request decode
  //////////////////////////////

  always_comb begin
    if (unit_i) begin
      kind_d = kind_unit;
    end else if (strided_i) begin
      kind_d = kind_strided;
    end else if (indexed_i) begin
      kind_d = kind_indexed;
    end else begin
      kind_d = kind_unit;
    end
  end

  assign emul = calc_emul(width_i, sew_i, lmul_i);

  // Indexed stores keep vtype for data, EEW/EMUL apply to the indices
  always_comb begin
    if (kind_d == kind_indexed) begin
      data_sew_d  = sew_i;
      data_lmul_d = lmul_i;
    end else begin
      data_sew_d  = width_i;
      data_lmul_d = emul;
    end
    idx_sew_d  = width_i;
    idx_lmul_d = emul;
  end

  //////////////////////////////
  // Capture
  //////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      kind_q      <= kind_unit;
      data_sew_q  <= '0;
      data_lmul_q <= '0;
      idx_sew_q   <= '0;
      idx_lmul_q  <= '0;
      base_addr_q <= '0;
      stride_q    <= '0;
    end else if (cfg.accept) begin
      kind_q      <= kind_d;
      data_sew_q  <= data_sew_d;
      data_lmul_q <= data_lmul_d;
      idx_sew_q   <= idx_sew_d;
      idx_lmul_q  <= idx_lmul_d;
      base_addr_q <= base_addr_i;
      stride_q    <= stride_i;
    end
  end

  // Bypass in the accept cycle so the FSM can branch on the new type
  assign cfg.kind      = cfg.accept ? kind_d      : kind_q;
  assign cfg.data_sew  = cfg.accept ? data_sew_d  : data_sew_q;
  assign cfg.data_lmul = cfg.accept ? data_lmul_d : data_lmul_q;
  assign cfg.idx_sew   = cfg.accept ? idx_sew_d   : idx_sew_q;
  assign cfg.idx_lmul  = cfg.accept ? idx_lmul_d  : idx_lmul_q;
  assign cfg.base_addr = cfg.accept ? base_addr_i : base_addr_q;
  assign cfg.stride    = cfg.accept ? stride_i    : stride_q;

endmodule

`default_nettype wire

// ==== mcu_store_fsm.sv ====
/*
  Store sequencer. The request valid is registered, so it acts one cycle late.
  Strided and indexed stores move one element per write burst.
*/
`timescale 1ns/1ps
`default_nettype none

module mcu_store_fsm import mcu_pkg::*; (
  input  wire logic clk,
  input  wire logic rstn,
  input  wire logic st_vld_i,
  output logic      st_rdy_o,
  mcu_store_cfg_if.cfg_snk cfg,
  input  wire logic vlane_store_valid_i,
  input  wire logic sbuff_write_done_i,
  input  wire logic sbuff_read_done_i,
  output logic      sbuff_wen_o,
  output logic      sbuff_ren_o,
  output logic      sbuff_read_stall_o,
  output logic      sbuff_read_flush_o,
  output logic      store_cfg_update_o,
  output logic      store_cntr_rst_o,
  output logic      store_baseaddr_set_o,
  output logic      store_baseaddr_update_o,
  output logic      ctrl_wstart_o,
  input  wire logic ctrl_wdone_i,
  output logic      wr_tvalid_o,
  input  wire logic wr_tready_i
);

  store_state_e             state_q, state_d;
  logic                     st_vld_q;
  logic                     accept;
  // Valid bits travelling alongside the buffer read data
  logic [WR_PIPE_DEPTH-1:0] pipe_q;
  logic                     pipe_in;
  logic                     pipe_empty;
  logic                     invalidate;

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      st_vld_q <= 1'b0;
      state_q  <= s_idle;
    end else begin
      st_vld_q <= st_vld_i;
      state_q  <= state_d;
    end
  end

  // Frozen while the buffer read is stalled
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pipe_q <= '0;
    end else if (!sbuff_read_stall_o) begin
      pipe_q <= {pipe_q[WR_PIPE_DEPTH-2:0], pipe_in};
    end
  end

  assign pipe_empty  = (pipe_q == '0);
  assign wr_tvalid_o = invalidate ? 1'b0 : pipe_q[WR_PIPE_DEPTH-1];

  assign accept             = (state_q == s_idle) && st_vld_q;
  assign cfg.accept         = accept;
  assign store_cfg_update_o = accept;
  assign store_cntr_rst_o   = accept;
  assign sbuff_read_flush_o = 1'b0;

  //////////////////////////////
  // Next state and strobes
  //////////////////////////////

  always_comb begin
    state_d                 = state_q;
    st_rdy_o                = 1'b0;
    sbuff_wen_o             = 1'b0;
    sbuff_ren_o             = 1'b0;
    sbuff_read_stall_o      = 1'b0;
    store_baseaddr_set_o    = 1'b0;
    store_baseaddr_update_o = 1'b0;
    ctrl_wstart_o           = 1'b0;
    pipe_in                 = 1'b0;
    invalidate              = 1'b0;

    case (state_q)
      s_idle: begin
        st_rdy_o   = 1'b1;
        // Leftover read data of the last store is not offered
        invalidate = !wr_tready_i;
        if (accept) begin
          store_baseaddr_set_o = 1'b1;
          pipe_in              = 1'b1;
          case (cfg.kind)
            kind_unit:    state_d = s_unit_prep;
            kind_strided: state_d = s_strided_prep;
            default:      state_d = s_indexed_prep;
          endcase
        end
      end

      // Unit stride, one burst for the whole vector
      s_unit_prep: begin
        if (sbuff_write_done_i) begin
          ctrl_wstart_o = 1'b1;
          sbuff_ren_o   = 1'b1;
          pipe_in       = 1'b1;
          state_d       = s_unit_tx;
        end else begin
          sbuff_wen_o = vlane_store_valid_i;
        end
      end

      s_unit_tx: begin
        if (wr_tready_i) begin
          sbuff_ren_o = !sbuff_read_done_i;
          pipe_in     = !sbuff_read_done_i;
        end else begin
          sbuff_read_stall_o = 1'b1;
          invalidate         = 1'b1;
        end
        if (sbuff_read_done_i && ctrl_wdone_i) begin
          state_d = s_idle;
        end
      end

      s_strided_prep: begin
        if (sbuff_write_done_i) begin
          store_baseaddr_set_o = 1'b1;
          sbuff_ren_o          = 1'b1;
          pipe_in              = 1'b1;
          state_d              = s_strided_tx_prep;
        end else begin
          sbuff_wen_o = vlane_store_valid_i;
        end
      end

      // Wait for the first index at the pipeline output
      s_indexed_prep: begin
        if (sbuff_write_done_i) begin
          sbuff_ren_o = 1'b1;
          pipe_in     = 1'b1;
          if (pipe_q[WR_PIPE_DEPTH-1]) begin
            store_baseaddr_update_o = 1'b1;
            state_d                 = s_indexed_tx_prep;
          end else begin
            store_baseaddr_set_o = 1'b1;
          end
        end else begin
          sbuff_wen_o = vlane_store_valid_i;
        end
      end

      // One element per burst, read the next one meanwhile
      s_strided_tx_prep, s_indexed_tx_prep: begin
        sbuff_ren_o   = !sbuff_read_done_i;
        pipe_in       = !sbuff_read_done_i;
        ctrl_wstart_o = 1'b1;
        invalidate    = 1'b1;
        state_d = (state_q == s_strided_tx_prep) ? s_strided_tx : s_indexed_tx;
      end

      s_strided_tx, s_indexed_tx: begin
        sbuff_read_stall_o = 1'b1;
        invalidate         = !wr_tready_i;
        if (ctrl_wdone_i) begin
          store_baseaddr_update_o = 1'b1;
          if (sbuff_read_done_i && pipe_empty) begin
            state_d = s_idle;
          end else if (state_q == s_strided_tx) begin
            state_d = s_strided_tx_prep;
          end else begin
            state_d = s_indexed_tx_prep;
          end
        end
      end

      default: begin
        state_d = s_idle;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== mcu_store_ctrl.sv ====
/*
  Store side of the vector memory control unit. Config outputs follow the
  request in the accept cycle and then hold until the next accept.
*/
`timescale 1ns/1ps
`default_nettype none

module mcu_store_ctrl import mcu_pkg::*; (
  input  wire logic   clk,
  input  wire logic   rstn,
  // Scheduler request
  input  wire vcode_t sew_i,
  input  wire vcode_t lmul_i,
  input  wire vcode_t width_i,
  input  wire addr_t  base_addr_i,
  input  wire addr_t  stride_i,
  input  wire logic   unit_i,
  input  wire logic   strided_i,
  input  wire logic   indexed_i,
  input  wire logic   st_vld_i,
  output logic        st_rdy_o,
  // Buffer array configuration
  output store_kind_e store_type_o,
  output addr_t       store_base_addr_o,
  output addr_t       store_stride_o,
  output vcode_t      cfg_store_data_sew_o,
  output vcode_t      cfg_store_data_lmul_o,
  output vcode_t      cfg_store_idx_sew_o,
  output vcode_t      cfg_store_idx_lmul_o,
  // Store buffer control
  input  wire logic   vlane_store_valid_i,
  input  wire logic   sbuff_write_done_i,
  input  wire logic   sbuff_read_done_i,
  output logic        sbuff_wen_o,
  output logic        sbuff_ren_o,
  output logic        sbuff_read_stall_o,
  output logic        sbuff_read_flush_o,
  output logic        store_cfg_update_o,
  output logic        store_cntr_rst_o,
  output logic        store_baseaddr_set_o,
  output logic        store_baseaddr_update_o,
  // Write channel
  output logic        ctrl_wstart_o,
  input  wire logic   ctrl_wdone_i,
  output logic        wr_tvalid_o,
  input  wire logic   wr_tready_i
);

  mcu_store_cfg_if cfg_if ();

  mcu_store_cfg u_cfg (
    .clk         (clk),
    .rstn        (rstn),
    .sew_i       (sew_i),
    .lmul_i      (lmul_i),
    .width_i     (width_i),
    .base_addr_i (base_addr_i),
    .stride_i    (stride_i),
    .unit_i      (unit_i),
    .strided_i   (strided_i),
    .indexed_i   (indexed_i),
    .cfg         (cfg_if.cfg_src)
  );

  mcu_store_fsm u_fsm (
    .clk                     (clk),
    .rstn                    (rstn),
    .st_vld_i                (st_vld_i),
    .st_rdy_o                (st_rdy_o),
    .cfg                     (cfg_if.cfg_snk),
    .vlane_store_valid_i     (vlane_store_valid_i),
    .sbuff_write_done_i      (sbuff_write_done_i),
    .sbuff_read_done_i       (sbuff_read_done_i),
    .sbuff_wen_o             (sbuff_wen_o),
    .sbuff_ren_o             (sbuff_ren_o),
    .sbuff_read_stall_o      (sbuff_read_stall_o),
    .sbuff_read_flush_o      (sbuff_read_flush_o),
    .store_cfg_update_o      (store_cfg_update_o),
    .store_cntr_rst_o        (store_cntr_rst_o),
    .store_baseaddr_set_o    (store_baseaddr_set_o),
    .store_baseaddr_update_o (store_baseaddr_update_o),
    .ctrl_wstart_o           (ctrl_wstart_o),
    .ctrl_wdone_i            (ctrl_wdone_i),
    .wr_tvalid_o             (wr_tvalid_o),
    .wr_tready_i             (wr_tready_i)
  );

  assign store_type_o          = cfg_if.kind;
  assign store_base_addr_o     = cfg_if.base_addr;
  assign store_stride_o        = cfg_if.stride;
  assign cfg_store_data_sew_o  = cfg_if.data_sew;
  assign cfg_store_data_lmul_o = cfg_if.data_lmul;
  assign cfg_store_idx_sew_o   = cfg_if.idx_sew;
  assign cfg_store_idx_lmul_o  = cfg_if.idx_lmul;

endmodule

`default_nettype wire

// ==== tb_mcu_checker.sv ====
/*
  Watches the store control ports and compares against a reference model.
  Samples on the falling clock edge, where all inputs and outputs are stable.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_mcu_checker (
  input  wire logic        clk,
  input  wire logic        rstn,
  input  wire logic [2:0]  sew_i, lmul_i, width_i,
  input  wire logic [31:0] base_addr_i, stride_i,
  input  wire logic        unit_i, strided_i, indexed_i, st_rdy_o,
  input  wire logic [1:0]  store_type_o,
  input  wire logic [31:0] store_base_addr_o, store_stride_o,
  input  wire logic [2:0]  cfg_store_data_sew_o, cfg_store_data_lmul_o,
  input  wire logic [2:0]  cfg_store_idx_sew_o, cfg_store_idx_lmul_o,
  input  wire logic        vlane_store_valid_i, sbuff_write_done_i,
  input  wire logic        sbuff_wen_o, sbuff_ren_o, sbuff_read_stall_o,
  input  wire logic        sbuff_read_flush_o,
  input  wire logic        store_cfg_update_o, store_cntr_rst_o,
  input  wire logic        store_baseaddr_set_o, store_baseaddr_update_o,
  input  wire logic        ctrl_wstart_o, ctrl_wdone_i, wr_tvalid_o, wr_tready_i,
  input  wire logic        end_i,
  output int               err_total_o,
  output logic             report_done_o
);

  int          errs [6];
  int          chks [6];
  logic [1:0]  exp_kind;
  logic [2:0]  exp_dsew, exp_dlmul, exp_isew, exp_ilmul, exp_emul;
  logic [31:0] exp_base, exp_stride;
  logic        cmp_pending, phase, busy, started, wdone_prev, rst_after;
  int          wstart_cnt, upd_cnt, wdone_cnt, accepts, completions;

  initial begin
    errs = '{default: 0};
    chks = '{default: 0};
    {cmp_pending, phase, busy, started, wdone_prev} = '0;
    rst_after = 1'b1;
    {wstart_cnt, upd_cnt, wdone_cnt, accepts, completions} = '0;
    err_total_o = 0;
    report_done_o = 1'b0;
  end

  function automatic string test_name(input int t);
    case (t)
      0: return "reset";
      1: return "captured configuration";
      2: return "write phase";
      3: return "unit store";
      4: return "strided and indexed";
      default: return "back-pressure";
    endcase
  endfunction

  // LMUL in eighths, so fractional values stay integer
  function automatic int lmul_eighths(input logic [2:0] c);
    case (c)
      3'd0: return 8;
      3'd1: return 16;
      3'd2: return 32;
      3'd3: return 64;
      3'd5: return 1;
      3'd6: return 2;
      3'd7: return 4;
      default: return 0;
    endcase
  endfunction

  function automatic logic [2:0] eighths_code(input int e);
    case (e)
      1: return 3'd5;
      2: return 3'd6;
      4: return 3'd7;
      8: return 3'd0;
      16: return 3'd1;
      32: return 3'd2;
      64: return 3'd3;
      default: return 3'd4;
    endcase
  endfunction

  task automatic check(input int t, input logic ok, input string msg);
    chks[t]++;
    if (!ok) begin
      errs[t]++;
      $display("Error at %0d ns: %s", $time, msg);
    end
  endtask

  always @(negedge clk) begin
    if (!rstn || rst_after) begin
      check(0, st_rdy_o && !sbuff_wen_o && !sbuff_ren_o && !sbuff_read_stall_o &&
            !sbuff_read_flush_o, "ready or buffer strobes wrong after reset");
      check(0, !store_cfg_update_o && !store_cntr_rst_o && !store_baseaddr_set_o &&
            !store_baseaddr_update_o && !ctrl_wstart_o && !wr_tvalid_o,
            "control strobes or tvalid high after reset");
      check(0, store_base_addr_o == 32'd0, "base address not cleared by reset");
      rst_after = !rstn;
    end else begin
      if (cmp_pending) begin
        check(1, store_type_o == exp_kind, "store type differs from request");
        check(1, store_base_addr_o == exp_base && store_stride_o == exp_stride,
              "base address or stride differs from request");
        check(1, cfg_store_data_sew_o == exp_dsew && cfg_store_data_lmul_o == exp_dlmul,
              "data SEW/LMUL differs from model");
        check(1, cfg_store_idx_sew_o == exp_isew && cfg_store_idx_lmul_o == exp_ilmul,
              "index SEW/LMUL differs from model");
        cmp_pending = 1'b0;
      end
      check(1, store_cntr_rst_o == store_cfg_update_o,
            "counter reset does not pulse with config update");
      check(2, sbuff_wen_o == (phase && !sbuff_write_done_i && vlane_store_valid_i),
            "buffer write enable does not follow lane valid");
      if (phase) check(2, !st_rdy_o, "ready high before store completed");
      if (started) check(5, !(wr_tvalid_o && !wr_tready_i), "tvalid high without tready");
      if (started && busy && !st_rdy_o && exp_kind == 2'd0 && !wr_tready_i) begin
        check(5, sbuff_read_stall_o && !sbuff_ren_o, "buffer read not stalled without tready");
      end
      if (started && store_baseaddr_update_o) upd_cnt++;
      if (busy && ctrl_wdone_i && !wdone_prev) wdone_cnt++;
      wdone_prev = ctrl_wdone_i;
      if (busy && ctrl_wstart_o) wstart_cnt++;
      if (busy && st_rdy_o) begin
        completions++;
        busy = 1'b0;
        if (exp_kind == 2'd0) begin
          check(3, wstart_cnt == 1, "unit store did not start exactly one burst");
        end else begin
          check(4, wdone_cnt > 0 && upd_cnt == wdone_cnt,
                "address updates do not match completed bursts");
        end
      end
      if (phase && sbuff_write_done_i) phase = 1'b0;
      if (busy && ctrl_wstart_o) started = 1'b1;
      if (store_cfg_update_o) begin
        check(1, store_baseaddr_set_o, "base address set missing at accept");
        exp_kind   = unit_i ? 2'd0 : (strided_i ? 2'd1 : 2'd2);
        exp_emul   = eighths_code(lmul_eighths(lmul_i) * (8 << width_i) / (8 << sew_i));
        exp_dsew   = (exp_kind == 2'd2) ? sew_i : width_i;
        exp_dlmul  = (exp_kind == 2'd2) ? lmul_i : exp_emul;
        exp_isew   = width_i;
        exp_ilmul  = exp_emul;
        exp_base   = base_addr_i;
        exp_stride = stride_i;
        {cmp_pending, phase, busy, started} = 4'b1110;
        {wstart_cnt, upd_cnt, wdone_cnt} = '0;
        accepts++;
      end
      if (end_i && !report_done_o) begin
        check(4, accepts > 0 && accepts == completions && !busy,
              "not every accepted store completed");
        for (int t = 0; t < 6; t++) begin
          $display("%-24s checks %0d errors %0d", test_name(t), chks[t], errs[t]);
          err_total_o += errs[t];
        end
        $display("Stores %0d, total errors %0d", accepts, err_total_o);
        report_done_o = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_mcu_store.sv ====
/*
  Testbench for the vector store control. Stimulus uses only valid EMUL
  combinations and widths up to 32 bit. Buffers and write channel are modeled.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_mcu_store;

  localparam int NUM_STORES = 40;
  localparam int CLK_PERIOD = 20;
  localparam int STORE_CYCLES = 200;
  localparam logic [31:0] SEED = 32'h3f1e0920;

  logic        clk;
  logic        rstn;
  logic [2:0]  sew_i, lmul_i, width_i;
  logic [31:0] base_addr_i, stride_i;
  logic        unit_i, strided_i, indexed_i, st_vld_i, st_rdy_o;
  logic [1:0]  store_type_o;
  logic [31:0] store_base_addr_o, store_stride_o;
  logic [2:0]  cfg_store_data_sew_o, cfg_store_data_lmul_o;
  logic [2:0]  cfg_store_idx_sew_o, cfg_store_idx_lmul_o;
  logic        vlane_store_valid_i = 1'b0;
  logic        sbuff_write_done_i = 1'b0;
  logic        sbuff_read_done_i = 1'b0;
  logic        sbuff_wen_o, sbuff_ren_o, sbuff_read_stall_o, sbuff_read_flush_o;
  logic        store_cfg_update_o, store_cntr_rst_o;
  logic        store_baseaddr_set_o, store_baseaddr_update_o;
  logic        ctrl_wstart_o, wr_tvalid_o;
  logic        ctrl_wdone_i = 1'b0;
  logic        wr_tready_i = 1'b0;

  logic        tests_end;
  logic        report_done;
  int          err_total;
  logic [31:0] rng = SEED;
  logic [31:0] noise = SEED ^ 32'h9e3779b9;
  logic [3:0]  elem_cnt, wen_cnt, ren_cnt;
  logic [2:0]  wdone_wait;

  mcu_store_ctrl u_dut (.*);

  tb_mcu_checker u_chk (
    .end_i         (tests_end),
    .err_total_o   (err_total),
    .report_done_o (report_done),
    .*
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////
  // Buffer and write channel
  //////////////////////////////

  always @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      vlane_store_valid_i <= 1'b0;
      wr_tready_i         <= 1'b0;
      sbuff_write_done_i  <= 1'b0;
      sbuff_read_done_i   <= 1'b0;
      ctrl_wdone_i        <= 1'b0;
      wen_cnt             <= '0;
      ren_cnt             <= '0;
      wdone_wait          <= '0;
    end else begin
      noise = xorshift32(noise);
      vlane_store_valid_i <= noise[0];
      // Ready about three cycles in four
      wr_tready_i         <= noise[1] | noise[2];
      if (store_cfg_update_o) begin
        wen_cnt            <= '0;
        ren_cnt            <= '0;
        sbuff_write_done_i <= 1'b0;
        sbuff_read_done_i  <= 1'b0;
        ctrl_wdone_i       <= 1'b0;
        wdone_wait         <= '0;
      end else begin
        if (sbuff_wen_o) begin
          wen_cnt <= wen_cnt + 4'd1;
          if (wen_cnt + 4'd1 >= elem_cnt) sbuff_write_done_i <= 1'b1;
        end
        if (sbuff_ren_o) begin
          ren_cnt <= ren_cnt + 4'd1;
          if (ren_cnt + 4'd1 >= elem_cnt) sbuff_read_done_i <= 1'b1;
        end
        // Done level holds until the next burst starts
        if (ctrl_wstart_o) begin
          ctrl_wdone_i <= 1'b0;
          wdone_wait   <= 3'(32'd1 + (noise >> 8) % 32'd6);
        end else if (wdone_wait == 3'd1) begin
          ctrl_wdone_i <= 1'b1;
          wdone_wait   <= '0;
        end else if (wdone_wait > 3'd1) begin
          wdone_wait <= wdone_wait - 3'd1;
        end
      end
    end
  end

  //////////////////////////////
  // Store requests
  //////////////////////////////

  initial begin
    int kind;
    int w;
    int s;
    int emul_log;
    int lmul_log;
    clk = 1'b0;
    rstn = 1'b0;
    {sew_i, lmul_i, width_i} = '0;
    {base_addr_i, stride_i} = '0;
    {unit_i, strided_i, indexed_i, st_vld_i} = '0;
    elem_cnt = 4'd1;
    tests_end = 1'b0;
    repeat (2) @(posedge clk);
    rstn <= 1'b1;
    for (int i = 0; i < NUM_STORES; i++) begin
      do @(negedge clk); while (!st_rdy_o);
      rng = xorshift32(rng);
      kind = int'(rng % 32'd3);
      w = int'((rng >> 4) % 32'd3);
      s = int'((rng >> 8) % 32'd3);
      lmul_log = 8;
      while (lmul_log < -3 || lmul_log > 3) begin
        rng = xorshift32(rng);
        emul_log = int'(rng % 32'd7) - 3;
        lmul_log = emul_log - w + s;
      end
      @(posedge clk);
      unit_i      <= (kind == 0);
      strided_i   <= (kind == 1);
      indexed_i   <= (kind == 2);
      width_i     <= w[2:0];
      sew_i       <= s[2:0];
      lmul_i      <= lmul_log[2:0];
      base_addr_i <= xorshift32(rng);
      stride_i    <= rng & 32'h0000_00fc;
      elem_cnt    <= 4'(32'd1 + (rng >> 16) % 32'd8);
      st_vld_i    <= 1'b1;
      @(posedge clk);
      st_vld_i <= 1'b0;
      do @(negedge clk); while (!store_cfg_update_o);
    end
    do @(negedge clk); while (!st_rdy_o);
    repeat (4) @(posedge clk);
    tests_end <= 1'b1;
    do @(negedge clk); while (!report_done);
    if (err_total == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(NUM_STORES * STORE_CYCLES * CLK_PERIOD);
    $display("Watchdog expired before all stores completed");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
mcu_pkg.sv
mcu_store_cfg_if.sv
mcu_store_cfg.sv
mcu_store_fsm.sv
mcu_store_ctrl.sv
tb_mcu_checker.sv
tb_mcu_store.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build and run the store control testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_mcu_store -f filelist.f -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "^TESTS PASSED$" sim.log && exit 0 || exit 1
